//--- logic/crc16_modbus.sv
/*
 Byte-serial Modbus CRC-16, one byte per cycle.
 clr together with valid folds the byte into a fresh CRC_INIT.
*/
`default_nettype none
`timescale 1ns/10ps

module crc16_modbus (
  input  logic              clk,
  input  logic              rst,
  input  logic              clr,
  input  modbus_pkg::byte_t data,
  input  logic              valid,
  output modbus_pkg::crc_t  crc
);
  import modbus_pkg::*;

  crc_t seed;
  crc_t crc_next;

  assign seed = clr ? CRC_INIT : crc;

  // Eight shift steps of the reflected polynomial
  always_comb begin
    crc_next = seed ^ crc_t'(data);
    for (int b = 0; b < 8; b++) begin
      crc_next = crc_next[0] ? ((crc_next >> 1) ^ CRC_POLY) : (crc_next >> 1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      crc <= CRC_INIT;
    end else if (valid) begin
      crc <= crc_next;
    end else if (clr) begin
      crc <= CRC_INIT;
    end
  end

endmodule

`default_nettype wire

//--- logic/frame_rx.sv
/*
 Single frame buffer with running CRC check. BUF_DEPTH is a power of two,
 8 to 65536. Bytes past BUF_DEPTH are dropped but still enter the CRC.
 New frames are ignored while a frame is held.
*/
`default_nettype none
`timescale 1ns/10ps

module frame_rx #(
  parameter int BUF_DEPTH = 256
) (
  input  logic                   clk,
  input  logic                   rst,
  input  modbus_pkg::rx_stream_t rx,
  output logic                   frame_valid,
  input  logic                   frame_ready,
  output modbus_pkg::word_t      frame_len,
  input  modbus_pkg::word_t      buf_idx,
  output modbus_pkg::byte_t      buf_byte,
  output logic                   crc_err
);
  import modbus_pkg::*;

  localparam int BUF_AW = $clog2(BUF_DEPTH);

  byte_t mem [BUF_DEPTH];
  word_t len;
  logic  collecting;
  logic  pending;
  logic  held;
  logic  busy;
  logic  start;
  logic  take;
  logic  len_ok;
  logic  accept;
  crc_t  crc;

  assign busy  = held | pending;
  assign start = rx.valid & rx.sof & ~busy;
  assign take  = start | (rx.valid & collecting & ~busy);

  // CRC runs over the whole frame including its CRC bytes
  crc16_modbus crc_i (
    .clk   (clk),
    .rst   (rst),
    .clr   (start),
    .data  (rx.data),
    .valid (take),
    .crc   (crc)
  );

  always_ff @(posedge clk) begin
    if (take && (start || len < BUF_DEPTH)) begin
      mem[start ? '0 : len[BUF_AW-1:0]] <= rx.data;
    end
    buf_byte <= mem[buf_idx[BUF_AW-1:0]];
  end

  // ====================
  // Frame control
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      len        <= '0;
      collecting <= 1'b0;
      pending    <= 1'b0;
      held       <= 1'b0;
    end else begin
      pending <= 1'b0;
      if (start) begin
        len        <= 16'd1;
        collecting <= 1'b1;
      end else if (take && len < BUF_DEPTH) begin
        len <= len + 16'd1;
      end
      // eof may trail the last byte
      if (rx.eof && (collecting || start)) begin
        collecting <= 1'b0;
        pending    <= 1'b1;
      end
      if (held) begin
        held <= ~frame_ready;
      end else begin
        held <= accept;
      end
    end
  end

  // Judged in the cycle after eof, a good frame leaves a zero residue
  assign len_ok      = len >= 16'd4;
  assign accept      = pending & len_ok & (crc == '0);
  assign crc_err     = pending & len_ok & (crc != '0);
  assign frame_valid = held | accept;
  assign frame_len   = len;

endmodule

`default_nettype wire

//--- logic/holding_regs.sv
/*
 Holding-register image, cleared by reset. REG_WORDS is a power of two;
 only the low address bits index the array, so addresses wrap.
*/
`default_nettype none
`timescale 1ns/10ps

module holding_regs #(
  parameter int REG_WORDS = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  modbus_pkg::word_t waddr,
  input  modbus_pkg::word_t wdata,
  input  modbus_pkg::word_t raddr,
  output modbus_pkg::word_t rdata
);
  import modbus_pkg::*;

  localparam int REG_AW = $clog2(REG_WORDS);

  word_t regs [REG_WORDS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr[REG_AW-1:0]] <= wdata;
    end
    // Read data one cycle after the address
    rdata <= regs[raddr[REG_AW-1:0]];
  end

endmodule

`default_nettype wire

//--- logic/modbus_pkg.sv
/*
 Shared types and constants for the Modbus RTU slave core.
 Register and buffer sizes are module parameters and are not set here.
*/
`default_nettype none

package modbus_pkg;

  // ====================
  // Widths with a meaning
  // ====================
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [15:0] crc_t;

  // Modbus CRC-16, reflected form
  localparam crc_t CRC_INIT = 16'hFFFF;
  localparam crc_t CRC_POLY = 16'hA001;

  // Supported function codes
  localparam byte_t FC_READ_HOLDING = 8'h03;
  localparam byte_t FC_WRITE_SINGLE = 8'h06;
  localparam byte_t FC_WRITE_MULTI  = 8'h10;

  // ====================
  // Streams
  // ====================
  // Byte from the UART bridge with frame marks
  typedef struct packed {
    byte_t data;
    logic  valid;
    logic  sof;
    logic  eof;
  } rx_stream_t;

  // Response body byte, last marks the byte before the CRC
  typedef struct packed {
    byte_t data;
    logic  last;
  } rsp_stream_t;

  typedef enum logic [3:0] {
    EX_IDLE,
    EX_HDR,
    EX_DISPATCH,
    EX_RD_HEAD,
    EX_RD_REQ,
    EX_RD_HI,
    EX_RD_LO,
    EX_WR_DATA,
    EX_ECHO,
    EX_RELEASE
  } exec_state_t;

  typedef enum logic [1:0] {
    TX_BODY,
    TX_CRC_LO,
    TX_CRC_HI
  } tx_state_t;

endpackage

`default_nettype wire

//--- logic/modbus_slave_top.sv
/*
 Modbus RTU slave, holding registers only. REG_WORDS must be a power of two.
 stat_crc_err is sticky until reset.
*/
`default_nettype none
`timescale 1ns/10ps

module modbus_slave_top #(
  parameter int REG_WORDS = 64,
  parameter int BUF_DEPTH = 256
) (
  input  logic                   clk,
  input  logic                   rst,
  input  modbus_pkg::rx_stream_t rx,
  output modbus_pkg::byte_t      tx_data,
  output logic                   tx_valid,
  input  logic                   tx_ready,
  input  modbus_pkg::word_t      reg_base,
  output logic                   stat_crc_err
);
  import modbus_pkg::*;

  logic        frame_valid;
  logic        frame_ready;
  word_t       frame_len;
  word_t       buf_idx;
  byte_t       buf_byte;
  logic        crc_err;
  logic        reg_we;
  word_t       reg_waddr;
  word_t       reg_wdata;
  word_t       reg_raddr;
  word_t       reg_rdata;
  rsp_stream_t rsp;
  logic        rsp_valid;
  logic        rsp_ready;

  frame_rx #(.BUF_DEPTH(BUF_DEPTH)) frame_rx_i (
    .clk(clk), .rst(rst), .rx(rx),
    .frame_valid(frame_valid), .frame_ready(frame_ready), .frame_len(frame_len),
    .buf_idx(buf_idx), .buf_byte(buf_byte), .crc_err(crc_err)
  );

  holding_regs #(.REG_WORDS(REG_WORDS)) holding_regs_i (
    .clk(clk), .rst(rst), .we(reg_we), .waddr(reg_waddr), .wdata(reg_wdata),
    .raddr(reg_raddr), .rdata(reg_rdata)
  );

  request_exec #(.REG_WORDS(REG_WORDS), .BUF_DEPTH(BUF_DEPTH)) request_exec_i (
    .clk(clk), .rst(rst), .reg_base(reg_base),
    .frame_valid(frame_valid), .frame_ready(frame_ready), .frame_len(frame_len),
    .buf_idx(buf_idx), .buf_byte(buf_byte),
    .reg_we(reg_we), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
    .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
    .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready)
  );

  response_tx response_tx_i (
    .clk(clk), .rst(rst), .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready)
  );

  // Sticky CRC error flag
  always_ff @(posedge clk) begin
    if (rst) begin
      stat_crc_err <= 1'b0;
    end else if (crc_err) begin
      stat_crc_err <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/request_exec.sv
/*
 Executes function codes 03, 06 and 10 on the held frame.
 Frames under 8 bytes or with other codes are released without a response.
 The device address is echoed, never filtered. REG_WORDS >= 2, BUF_DEPTH >= 8.
*/
`default_nettype none
`timescale 1ns/10ps

module request_exec #(
  parameter int REG_WORDS = 64,
  parameter int BUF_DEPTH = 256
) (
  input  logic                    clk,
  input  logic                    rst,
  input  modbus_pkg::word_t       reg_base,
  input  logic                    frame_valid,
  output logic                    frame_ready,
  input  modbus_pkg::word_t       frame_len,
  output modbus_pkg::word_t       buf_idx,
  input  modbus_pkg::byte_t       buf_byte,
  output logic                    reg_we,
  output modbus_pkg::word_t       reg_waddr,
  output modbus_pkg::word_t       reg_wdata,
  output modbus_pkg::word_t       reg_raddr,
  input  modbus_pkg::word_t       reg_rdata,
  output modbus_pkg::rsp_stream_t rsp,
  output logic                    rsp_valid,
  input  logic                    rsp_ready
);
  import modbus_pkg::*;

  localparam int BUF_AW = $clog2(BUF_DEPTH);
  localparam int REG_AW = $clog2(REG_WORDS);

  typedef logic [BUF_AW-1:0] bidx_t;
  typedef logic [REG_AW-1:0] ridx_t;

  exec_state_t state;
  byte_t [5:0] hdr;
  bidx_t       idx;
  ridx_t       ofs;
  logic        phase;
  word_t       cnt;
  byte_t       fc;
  word_t       start_addr;
  word_t       qty;
  word_t       rel_addr;
  byte_t       emit_byte;
  logic        emit_last;
  logic        emitting;
  logic        sent;

  // hdr[5] is the first frame byte
  assign fc          = hdr[4];
  assign start_addr  = {hdr[3], hdr[2]};
  assign qty         = {hdr[1], hdr[0]};
  assign rel_addr    = start_addr - reg_base;
  assign buf_idx     = word_t'(idx);
  assign reg_raddr   = word_t'(ofs);
  assign frame_ready = (state == EX_RELEASE);
  assign sent        = rsp_valid & rsp_ready;

  // ====================
  // Response byte select
  // ====================
  always_comb begin
    emitting  = 1'b1;
    emit_byte = '0;
    emit_last = 1'b0;
    case (state)
      EX_RD_HEAD: begin
        if (cnt == 16'd0) begin
          emit_byte = hdr[5];
        end else if (cnt == 16'd1) begin
          emit_byte = hdr[4];
        end else begin
          emit_byte = {qty[6:0], 1'b0};
        end
        emit_last = (cnt == 16'd2) && (qty == '0);
      end
      EX_RD_HI: emit_byte = reg_rdata[15:8];
      EX_RD_LO: begin
        emit_byte = reg_rdata[7:0];
        emit_last = (cnt + 16'd1 == qty);
      end
      EX_ECHO: begin
        emit_byte = hdr[3'd5 - cnt[2:0]];
        emit_last = (cnt == 16'd5);
      end
      default: emitting = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= EX_IDLE;
      rsp_valid <= 1'b0;
      reg_we    <= 1'b0;
      phase     <= 1'b0;
    end else begin
      reg_we <= 1'b0;
      if (emitting && !rsp_valid) begin
        rsp       <= '{data: emit_byte, last: emit_last};
        rsp_valid <= 1'b1;
      end else if (sent) begin
        rsp_valid <= 1'b0;
      end

      case (state)
        EX_IDLE: begin
          if (frame_valid) begin
            idx   <= '0;
            phase <= 1'b0;
            state <= EX_HDR;
          end
        end
        // Two cycles per buffer byte, address then data
        EX_HDR: begin
          phase <= ~phase;
          if (phase) begin
            hdr <= {hdr[4:0], buf_byte};
            idx <= idx + 1'b1;
            if (idx == bidx_t'(5)) begin
              state <= EX_DISPATCH;
            end
          end
        end
        EX_DISPATCH: begin
          ofs <= ridx_t'(rel_addr);
          cnt <= '0;
          idx <= bidx_t'(7);
          if (frame_len < 16'd8) begin
            state <= EX_RELEASE;
          end else begin
            case (fc)
              FC_READ_HOLDING: state <= EX_RD_HEAD;
              FC_WRITE_SINGLE: begin
                reg_we    <= 1'b1;
                reg_waddr <= rel_addr;
                reg_wdata <= qty;
                state     <= EX_ECHO;
              end
              FC_WRITE_MULTI: state <= (qty == '0) ? EX_ECHO : EX_WR_DATA;
              default: state <= EX_RELEASE;
            endcase
          end
        end
        EX_RD_HEAD: begin
          if (sent) begin
            cnt <= cnt + 16'd1;
            if (cnt == 16'd2) begin
              cnt   <= '0;
              state <= emit_last ? EX_RELEASE : EX_RD_REQ;
            end
          end
        end
        // Wait for the register read
        EX_RD_REQ: state <= EX_RD_HI;
        EX_RD_HI: begin
          if (sent) begin
            state <= EX_RD_LO;
          end
        end
        EX_RD_LO: begin
          if (sent) begin
            ofs   <= ofs + 1'b1;
            cnt   <= cnt + 16'd1;
            state <= emit_last ? EX_RELEASE : EX_RD_REQ;
          end
        end
        // Data words start at byte 7, high byte at odd index
        EX_WR_DATA: begin
          phase <= ~phase;
          if (phase) begin
            idx <= idx + 1'b1;
            if (idx[0]) begin
              reg_wdata[15:8] <= buf_byte;
            end else begin
              reg_wdata[7:0] <= buf_byte;
              reg_we         <= 1'b1;
              reg_waddr      <= word_t'(ofs);
              ofs            <= ofs + 1'b1;
              cnt            <= cnt + 16'd1;
              if (cnt + 16'd1 == qty) begin
                cnt   <= '0;
                state <= EX_ECHO;
              end
            end
          end
        end
        EX_ECHO: begin
          if (sent) begin
            cnt <= cnt + 16'd1;
            if (emit_last) begin
              state <= EX_RELEASE;
            end
          end
        end
        EX_RELEASE: state <= EX_IDLE;
        default: state <= EX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/response_tx.sv
/*
 Forwards response body bytes and appends the CRC, low byte first.
 Output is a registered valid/ready byte stream.
*/
`default_nettype none
`timescale 1ns/10ps

module response_tx (
  input  logic                    clk,
  input  logic                    rst,
  input  modbus_pkg::rsp_stream_t rsp,
  input  logic                    rsp_valid,
  output logic                    rsp_ready,
  output modbus_pkg::byte_t       tx_data,
  output logic                    tx_valid,
  input  logic                    tx_ready
);
  import modbus_pkg::*;

  tx_state_t state;
  crc_t      crc;
  logic      can_load;
  logic      body_take;
  logic      crc_clr;

  // Output register is free or drains this cycle
  assign can_load  = ~tx_valid | tx_ready;
  assign rsp_ready = (state == TX_BODY) & can_load;
  assign body_take = rsp_valid & rsp_ready;
  assign crc_clr   = (state == TX_CRC_HI) & can_load;

  crc16_modbus crc_i (
    .clk   (clk),
    .rst   (rst),
    .clr   (crc_clr),
    .data  (rsp.data),
    .valid (body_take),
    .crc   (crc)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= TX_BODY;
      tx_valid <= 1'b0;
    end else begin
      if (tx_ready) begin
        tx_valid <= 1'b0;
      end
      case (state)
        TX_BODY: begin
          if (body_take) begin
            tx_data  <= rsp.data;
            tx_valid <= 1'b1;
            if (rsp.last) begin
              state <= TX_CRC_LO;
            end
          end
        end
        TX_CRC_LO: begin
          if (can_load) begin
            tx_data  <= crc[7:0];
            tx_valid <= 1'b1;
            state    <= TX_CRC_HI;
          end
        end
        TX_CRC_HI: begin
          if (can_load) begin
            tx_data  <= crc[15:8];
            tx_valid <= 1'b1;
            state    <= TX_BODY;
          end
        end
        default: state <= TX_BODY;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- modbus_slave.f
+incdir+sim
logic/modbus_pkg.sv
logic/crc16_modbus.sv
logic/frame_rx.sv
logic/holding_regs.sv
logic/request_exec.sv
logic/response_tx.sv
logic/modbus_slave_top.sv
sim/clk_gen.sv
sim/tb_modbus_slave.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Modbus slave testbench with Verilator, output in sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_modbus_slave \
  -f modbus_slave.f -o tb_modbus_slave || exit 1

./obj_dir/tb_modbus_slave > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

grep -q "Test FAILED" sim.log && exit 1 || exit 0

//--- sim/clk_gen.sv
/*
 Testbench clock and reset. Period 10 ns, rst high for RST_CYCLES edges.
*/
`default_nettype none
`timescale 1ns/10ps

module clk_gen #(
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/tb_frames.svh
/*
 Frame helpers, included inside tb_modbus_slave.
 They use the module's clk, rx, req_q and got_q and its CRC mode constants.
*/
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

// Modbus CRC-16, one bit at a time
function automatic logic [15:0] crc_of(input byte_t q[$]);
  logic [15:0] crc;
  crc = 16'hFFFF;
  foreach (q[i]) begin
    crc = crc ^ {8'h00, q[i]};
    for (int b = 0; b < 8; b++) begin
      crc = crc[0] ? ((crc >> 1) ^ 16'hA001) : (crc >> 1);
    end
  end
  return crc;
endfunction

// Append the CRC as asked and drive the frame, one byte per clock
task automatic send_frame(input logic [1:0] crc_mode);
  byte_t       frame[$];
  logic [15:0] crc;
  frame = req_q;
  crc = crc_of(req_q);
  if (crc_mode == CRC_BAD) begin
    crc = crc ^ 16'h0100;
  end
  if (crc_mode != CRC_NONE) begin
    frame.push_back(crc[7:0]);
    frame.push_back(crc[15:8]);
  end
  foreach (frame[i]) begin
    @(posedge clk);
    rx <= '{data: frame[i], valid: 1'b1, sof: (i == 0),
            eof: (i == frame.size() - 1)};
  end
  @(posedge clk);
  rx <= '0;
endtask

// Wait for n bytes, then a quiet spell that would catch extra bytes
task automatic collect_response(input int n, output logic ok);
  int cycles;
  int quiet;
  cycles = 0;
  quiet = (n == 0) ? 400 : 40;
  while (got_q.size() < n && cycles < 3000) begin
    @(posedge clk);
    cycles++;
  end
  ok = (got_q.size() >= n);
  cycles = 0;
  while (ok && cycles < quiet) begin
    @(posedge clk);
    cycles++;
  end
endtask

`endif

//--- sim/tb_modbus_slave.sv
/*
 Table-driven testbench for modbus_slave_top with a register model.
 reg_base is fixed at 100. tx_ready is random on rows marked stall.
 Immediate assertions must be enabled in the simulator.
*/
`default_nettype none
`timescale 1ns/10ps

module tb_modbus_slave;
  import modbus_pkg::*;

  localparam int    REG_WORDS = 64;
  localparam int    ROWS      = 14;
  localparam word_t BASE      = 16'd100;

  // CRC handling of a row
  localparam logic [1:0] CRC_GOOD = 2'd0;
  localparam logic [1:0] CRC_BAD  = 2'd1;
  localparam logic [1:0] CRC_NONE = 2'd2;
  // Expected response kind
  localparam logic [1:0] RSP_DATA    = 2'd0;
  localparam logic [1:0] RSP_NONE    = 2'd1;
  localparam logic [1:0] RSP_CRC_ERR = 2'd2;

  // Request bytes are right aligned, first byte at the top
  typedef struct packed {
    logic [4:0]   len;
    logic [127:0] req;
    logic [1:0]   crc_mode;
    logic [1:0]   kind;
    logic         stall;
  } row_t;

  logic       clk;
  logic       rst;
  rx_stream_t rx;
  byte_t      tx_data;
  logic       tx_valid;
  logic       tx_ready = 1'b1;
  word_t      reg_base;
  logic       stat_crc_err;
  logic       stall;
  word_t      model [REG_WORDS];
  row_t       rows [ROWS];
  byte_t      req_q[$];
  byte_t      exp_q[$];
  byte_t      got_q[$];
  int         checks;
  int         errors;
  logic       timed_out;

  clk_gen clk_gen_i (.clk(clk), .rst(rst));

  modbus_slave_top #(.REG_WORDS(REG_WORDS), .BUF_DEPTH(256)) modbus_slave_top_i (
    .clk(clk), .rst(rst), .rx(rx),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
    .reg_base(reg_base), .stat_crc_err(stat_crc_err)
  );

  always @(posedge clk) begin
    if (stall) begin
      tx_ready <= ($urandom % 3) != 0;
    end else begin
      tx_ready <= 1'b1;
    end
  end

  // A byte counts when valid and ready meet at the next edge
  always @(negedge clk) begin
    if (!rst && tx_valid && tx_ready) begin
      got_q.push_back(tx_data);
    end
  end

  `include "tb_frames.svh"

  task automatic check_val(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      $display("CHECK FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // ====================
  // Register model
  // ====================
  task automatic build_expected(input row_t r);
    byte_t       fc;
    word_t       qty;
    word_t       rel;
    int          idx;
    logic [15:0] crc;
    exp_q.delete();
    fc = req_q[1];
    rel = {req_q[2], req_q[3]} - BASE;
    qty = {req_q[4], req_q[5]};
    if (r.kind == RSP_DATA) begin
      if (fc == 8'h03) begin
        exp_q.push_back(req_q[0]);
        exp_q.push_back(fc);
        exp_q.push_back(byte_t'(qty << 1));
        for (int i = 0; i < qty; i++) begin
          idx = (int'(rel) + i) % REG_WORDS;
          exp_q.push_back(model[idx][15:8]);
          exp_q.push_back(model[idx][7:0]);
        end
      end else begin
        if (fc == 8'h06) begin
          model[int'(rel) % REG_WORDS] = qty;
        end else begin
          for (int i = 0; i < qty; i++) begin
            model[(int'(rel) + i) % REG_WORDS] = {req_q[7 + 2 * i], req_q[8 + 2 * i]};
          end
        end
        for (int i = 0; i < 6; i++) begin
          exp_q.push_back(req_q[i]);
        end
      end
      crc = crc_of(exp_q);
      exp_q.push_back(crc[7:0]);
      exp_q.push_back(crc[15:8]);
    end
  endtask

  task automatic load_table();
    rows[0]  = '{5'd6, 128'h11_06_00_69_BE_EF, CRC_GOOD, RSP_DATA, 1'b0};
    rows[1]  = '{5'd6, 128'h11_03_00_69_00_01, CRC_GOOD, RSP_DATA, 1'b0};
    rows[2]  = '{5'd15, 128'h11_10_00_6E_00_04_08_11_11_22_22_33_33_44_44,
                 CRC_GOOD, RSP_DATA, 1'b0};
    rows[3]  = '{5'd6, 128'h11_03_00_6E_00_04, CRC_GOOD, RSP_DATA, 1'b0};
    // 170 and 106 both land on register 6
    rows[4]  = '{5'd6, 128'h11_06_00_AA_5A_5A, CRC_GOOD, RSP_DATA, 1'b0};
    rows[5]  = '{5'd6, 128'h11_03_00_6A_00_01, CRC_GOOD, RSP_DATA, 1'b0};
    rows[6]  = '{5'd6, 128'h11_05_00_01_FF_00, CRC_GOOD, RSP_NONE, 1'b0};
    rows[7]  = '{5'd3, 128'h11_03_00, CRC_NONE, RSP_NONE, 1'b0};
    rows[8]  = '{5'd6, 128'h11_06_00_69_00_00, CRC_BAD, RSP_CRC_ERR, 1'b0};
    rows[9]  = '{5'd6, 128'h11_03_00_69_00_01, CRC_GOOD, RSP_DATA, 1'b0};
    rows[10] = '{5'd13, 128'h22_10_00_64_00_03_06_A1_01_B2_02_C3_03,
                 CRC_GOOD, RSP_DATA, 1'b1};
    rows[11] = '{5'd6, 128'h22_03_00_64_00_10, CRC_GOOD, RSP_DATA, 1'b1};
    rows[12] = '{5'd6, 128'h22_06_00_70_0F_F0, CRC_GOOD, RSP_DATA, 1'b1};
    rows[13] = '{5'd6, 128'h22_03_00_6C_00_06, CRC_GOOD, RSP_DATA, 1'b1};
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    row_t r;
    int   seed;
    int   cycles;
    int   err_before;
    logic flag_before;
    logic ok;
    seed = $urandom(45462);
    rx = '0;
    reg_base = BASE;
    stall = 1'b0;
    checks = 0;
    errors = 0;
    timed_out = 1'b0;
    foreach (model[i]) begin
      model[i] = '0;
    end
    load_table();

    // Reset is only looked at from the first clock edge on
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (rst !== 1'b0 && cycles < 20);
    if (rst !== 1'b0) begin
      $display("Reset never released");
      errors++;
      timed_out = 1'b1;
    end

    for (int t = 0; t < ROWS && !timed_out; t++) begin
      r = rows[t];
      req_q.delete();
      for (int i = int'(r.len) - 1; i >= 0; i--) begin
        req_q.push_back(r.req[8 * i +: 8]);
      end
      err_before = errors;
      flag_before = stat_crc_err;
      stall = r.stall;
      build_expected(r);
      got_q.delete();
      send_frame(r.crc_mode);
      collect_response(exp_q.size(), ok);
      if (!ok) begin
        $display("Row %0d timed out with %0d of %0d response bytes",
                 t, got_q.size(), exp_q.size());
        errors++;
        timed_out = 1'b1;
      end else begin
        check_val("response length", got_q.size(), exp_q.size());
        foreach (exp_q[i]) begin
          if (i < got_q.size()) begin
            check_val($sformatf("tx_data[%0d]", i), got_q[i], exp_q[i]);
          end
        end
        check_val("stat_crc_err", stat_crc_err, flag_before | (r.kind == RSP_CRC_ERR));
      end
      $display("row %0d fc %02h: %s", t, req_q[1],
               (errors == err_before) ? "passed" : "failed");
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
